// File: tb.f
verilog/bridge_cfg_pkg.sv
verilog/bridge_msg_pkg.sv
verilog/spi_byte_rx.sv
verilog/byte_fifo.sv
verilog/baud_timer.sv
verilog/uart_tx_seq.sv
verilog/pattern_match.sv
verilog/spi_uart_bridge.sv
testbench/tb_spi_uart_bridge.sv

// File: Bender.yml
package:
  name: spi_uart_bridge

sources:
  - verilog/bridge_cfg_pkg.sv
  - verilog/bridge_msg_pkg.sv
  - verilog/spi_byte_rx.sv
  - verilog/byte_fifo.sv
  - verilog/baud_timer.sv
  - verilog/uart_tx_seq.sv
  - verilog/pattern_match.sv
  - verilog/spi_uart_bridge.sv
  - target: simulation
    files:
      - testbench/tb_spi_uart_bridge.sv

// File: testbench/tb_spi_uart_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_uart_bridge import bridge_cfg_pkg::*, bridge_msg_pkg::*; ();

    localparam int     FRAME_CYC    = 10 * BIT_CYCLES;         // Start, 8 data, stop
    localparam int     TOTAL_FRAMES = 0 + 4 + 8 + 16 + 16 + 80;  // UART frames over all tests
    localparam longint WATCHDOG_NS  = longint'(TOTAL_FRAMES) * FRAME_CYC * 40 + 2_000_000;

    logic  Clock;
    logic  rst;
    logic  spi_sck;
    logic  spi_cs_n;
    logic  spi_mosi;
    logic  spi_miso;
    logic  uart_tx;
    logic  match;
    logic  overflow;
    byte_t rx_q[$];            // Bytes decoded from uart_tx
    byte_t sent_q[$];          // Bytes sent by the SPI master in this test
    string test_name;
    int    errors = 0;
    int    checks = 0;
    logic [31:0] lcg_state = 32'd40534;

    spi_uart_bridge DUT (
        .Clock    (Clock),
        .rst      (rst),
        .spi_sck  (spi_sck),
        .spi_cs_n (spi_cs_n),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .uart_tx  (uart_tx),
        .match    (match),
        .overflow (overflow)
    );

    initial begin
        Clock = 1'b0;
        forever #20 Clock = ~Clock;  // 25 MHz model of the board clock
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run is stopped", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic byte_t next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];  // Upper bits are the better ones
    endfunction

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %02h, actual %02h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // Samples each bit at the middle of its window
    task automatic uart_decode();
        byte_t data;
        int    i;
        forever begin
            @(negedge uart_tx);                         // Start bit edge
            repeat (BIT_CYCLES / 2) @(negedge Clock);
            check_bit({test_name, " start bit"}, 1'b0, uart_tx);
            for (i = 0; i < 8; i++) begin
                repeat (BIT_CYCLES) @(negedge Clock);
                data[i] = uart_tx;                      // LSB first
            end
            repeat (BIT_CYCLES) @(negedge Clock);
            check_bit({test_name, " stop bit"}, 1'b1, uart_tx);
            rx_q.push_back(data);
        end
    endtask

    task automatic cs_begin();
        @(posedge Clock);
        spi_cs_n <= 1'b0;
        repeat (8) @(posedge Clock);  // Reply byte loads after sync
    endtask

    task automatic cs_end();
        repeat (8) @(posedge Clock);
        spi_cs_n <= 1'b1;
        repeat (8) @(posedge Clock);
    endtask

    // Mode 0, MSB first, half period of 4 clocks
    task automatic spi_xfer(input byte_t tx, output byte_t rx);
        byte_t got;
        int    i;
        got = '0;
        for (i = 7; i >= 0; i--) begin
            spi_mosi <= tx[i];                          // Launch with SCK low
            repeat (3) @(posedge Clock);
            @(negedge Clock);
            got[i] = spi_miso;                          // Settled since the last fall
            @(posedge Clock);
            spi_sck <= 1'b1;
            repeat (4) @(posedge Clock);
            spi_sck <= 1'b0;
        end
        repeat (4) @(posedge Clock);                    // Gap between bytes
        rx = got;
    endtask

    task automatic send_bytes();
        byte_t reply;
        int    i;
        for (i = 0; i < sent_q.size(); i++) spi_xfer(sent_q[i], reply);
    endtask

    task automatic wait_for_bytes(input int n, input int limit);
        int waited;
        waited = 0;
        while (rx_q.size() < n && waited < limit) begin
            @(posedge Clock);
            waited++;
        end
        if (rx_q.size() < n) begin
            errors++;
            $display("Timeout in %s: only %0d of %0d UART bytes arrived",
                     test_name, rx_q.size(), n);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        rx_q.delete();
        sent_q.delete();
    endtask

    task automatic check_echo();
        int i;
        check_count({test_name, " byte count"}, sent_q.size(), rx_q.size());
        for (i = 0; i < sent_q.size() && i < rx_q.size(); i++)
            check_byte($sformatf("%s byte %0d", test_name, i), sent_q[i], rx_q[i]);
    endtask

    task automatic test_reset_state();
        start_test("reset_state");
        @(negedge Clock);
        check_bit("reset_state uart_tx", 1'b1, uart_tx);
        check_bit("reset_state match", 1'b0, match);
        check_bit("reset_state overflow", 1'b0, overflow);
        repeat (3 * FRAME_CYC) @(posedge Clock);        // Line must stay idle
        @(negedge Clock);
        check_count("reset_state frames", 0, rx_q.size());
        check_bit("reset_state idle line", 1'b1, uart_tx);
    endtask

    task automatic test_miso_reply();
        byte_t prev;
        byte_t tx;
        byte_t reply;
        int    k;
        start_test("miso_reply");
        prev = '0;                                      // Nothing received yet
        for (k = 0; k < 4; k++) begin
            tx = next_rand();
            sent_q.push_back(tx);
            cs_begin();
            spi_xfer(tx, reply);
            cs_end();
            check_byte($sformatf("miso_reply xfer %0d", k), prev, reply);
            prev = tx;
        end
        wait_for_bytes(4, 5 * FRAME_CYC);
        check_echo();
    endtask

    task automatic test_echo_order();
        int k;
        start_test("echo_order");
        for (k = 0; k < 8; k++) sent_q.push_back(next_rand());
        cs_begin();
        send_bytes();
        cs_end();
        wait_for_bytes(8, 9 * FRAME_CYC);
        check_echo();
    endtask

    task automatic test_pattern(input logic corrupt);
        int idx;
        int k;
        start_test(corrupt ? "pattern_mismatch" : "pattern_match");
        for (k = 0; k < MSG_LEN; k++) sent_q.push_back(DEBUG_MSG[k]);
        if (corrupt) begin
            idx = next_rand() % MSG_LEN;
            sent_q[idx] = sent_q[idx] ^ (next_rand() | 8'h01);  // Never the same byte
        end
        cs_begin();
        send_bytes();
        @(negedge Clock);
        check_bit({test_name, " match in frame"}, !corrupt, match);
        cs_end();
        @(negedge Clock);
        check_bit({test_name, " match after CS"}, 1'b0, match);
        wait_for_bytes(MSG_LEN, (MSG_LEN + 1) * FRAME_CYC);
        check_echo();
    endtask

    task automatic test_overflow();
        int i;
        int j;
        int last;
        int idle;
        start_test("overflow");
        for (i = 0; i < 80; i++) sent_q.push_back(next_rand());
        cs_begin();
        send_bytes();                                   // Much faster than the UART
        cs_end();
        @(negedge Clock);
        check_bit("overflow flag", 1'b1, overflow);
        wait_for_bytes(FIFO_DEPTH, (FIFO_DEPTH + 2) * FRAME_CYC);
        last = rx_q.size();
        idle = 0;
        while (idle < 2 * FRAME_CYC) begin              // Drain until the line goes quiet
            @(posedge Clock);
            if (rx_q.size() != last) begin
                last = rx_q.size();
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (rx_q.size() < FIFO_DEPTH) begin
            errors++;
            $display("Too few bytes after overflow: %0d decoded", rx_q.size());
        end
        for (i = 0; i < FIFO_DEPTH && i < rx_q.size(); i++)
            check_byte($sformatf("overflow byte %0d", i), sent_q[i], rx_q[i]);
        j = FIFO_DEPTH;
        // A pop during the burst can admit a later byte after a drop
        for (i = FIFO_DEPTH; i < rx_q.size(); i++) begin
            while (j < sent_q.size() && sent_q[j] !== rx_q[i]) j++;
            if (j >= sent_q.size()) begin
                errors++;
                $display("Decoded byte %0d (%02h) is not in send order", i, rx_q[i]);
            end
            j++;
        end
    endtask

    initial begin
        rst       = 1'b1;
        spi_sck   = 1'b0;
        spi_cs_n  = 1'b1;
        spi_mosi  = 1'b0;
        test_name = "init";
        repeat (10) @(posedge Clock);
        rst <= 1'b0;
        fork
            uart_decode();
        join_none
        test_reset_state();
        test_miso_reply();                              // Needs the zero reply after reset
        test_echo_order();
        test_pattern(1'b0);
        test_pattern(1'b1);
        test_overflow();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/spi_uart_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module spi_uart_bridge import bridge_msg_pkg::*; (
    input  logic Clock,     // 27 MHz board clock
    input  logic rst,       // Sync reset, active high
    input  logic spi_sck,   // SPI clock
    input  logic spi_cs_n,  // SPI chip select, active low
    input  logic spi_mosi,  // SPI data in
    output logic spi_miso,  // SPI data out, previous byte
    output logic uart_tx,   // UART transmit line
    output logic match,     // Debug message seen in this frame
    output logic overflow   // Queue dropped a byte
);

    byte_t rx_byte;    // SPI byte to queue and checker
    logic  rx_valid;
    logic  cs_active;
    byte_t pop_data;   // Queue head to UART
    logic  empty;
    logic  pop;
    logic  run;        // UART frame in progress
    logic  bit_tick;

    spi_byte_rx u_spi_rx (
        .Clock     (Clock),
        .rst       (rst),
        .sck       (spi_sck),
        .cs_n      (spi_cs_n),
        .mosi      (spi_mosi),
        .miso      (spi_miso),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .cs_active (cs_active)
    );

    byte_fifo u_fifo (
        .Clock     (Clock),
        .rst       (rst),
        .push      (rx_valid),
        .push_data (rx_byte),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (empty),
        .full      (),          // Drop logic is inside the queue
        .overflow  (overflow)
    );

    baud_timer u_baud (
        .Clock    (Clock),
        .rst      (rst),
        .run      (run),
        .bit_tick (bit_tick)
    );

    uart_tx_seq u_uart_tx (
        .Clock    (Clock),
        .rst      (rst),
        .empty    (empty),
        .pop_data (pop_data),
        .bit_tick (bit_tick),
        .pop      (pop),
        .run      (run),
        .uart_tx  (uart_tx)
    );

    pattern_match u_match (
        .Clock     (Clock),
        .rst       (rst),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .cs_active (cs_active),
        .match     (match)
    );

endmodule

`default_nettype wire

// File: verilog/pattern_match.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_match import bridge_msg_pkg::*; (
    input  logic  Clock,      // System clock
    input  logic  rst,        // Sync reset, active high
    input  byte_t rx_byte,    // Byte from SPI
    input  logic  rx_valid,   // Byte strobe
    input  logic  cs_active,  // Frame level
    output logic  match       // Frame carried the debug message
);

    logic [MSG_IDX_W:0] byte_idx;    // Bytes seen this frame, 0..MSG_LEN
    logic               all_eq;      // Every byte so far matched
    logic               frame_done;  // Pulse after the last message byte

    always_ff @(posedge Clock) begin
        if (rst || !cs_active) begin
            byte_idx   <= '0;          // Fresh count for the next frame
            all_eq     <= 1'b1;
            frame_done <= 1'b0;
            match      <= 1'b0;        // Drops once CS goes high
        end else begin
            frame_done <= 1'b0;
            if (rx_valid && byte_idx < MSG_LEN) begin
                byte_idx   <= byte_idx + 1'b1;
                all_eq     <= all_eq &&
                              (rx_byte == DEBUG_MSG[byte_idx[MSG_IDX_W-1:0]]);
                frame_done <= (byte_idx == MSG_LEN - 1);
            end
            // Extra bytes past the message leave the count at MSG_LEN
            if (frame_done) begin
                match <= all_eq;       // Sees the last compare too
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/uart_tx_seq.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_seq import bridge_msg_pkg::*; (
    input  logic  Clock,     // System clock
    input  logic  rst,       // Sync reset, active high
    input  logic  empty,     // Queue has nothing to send
    input  byte_t pop_data,  // Queue head
    input  logic  bit_tick,  // End of a bit period
    output logic  pop,       // Take the head byte
    output logic  run,       // Keeps the baud timer counting
    output logic  uart_tx    // Serial line, idles high
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } state_t;

    state_t     state;
    byte_t      shreg;    // Bits still to send, LSB next
    logic [2:0] bit_idx;  // Data bit on the line

    assign pop = (state == ST_IDLE) && !empty;  // Head latched on this edge
    assign run = (state != ST_IDLE);

    always_ff @(posedge Clock) begin
        if (rst) begin
            state   <= ST_IDLE;
            bit_idx <= '0;
            uart_tx <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: if (!empty) begin
                    state   <= ST_START;
                    uart_tx <= 1'b0;                  // Start bit
                end
                ST_START: if (bit_tick) begin
                    state   <= ST_DATA;
                    bit_idx <= '0;
                    uart_tx <= shreg[0];              // Data bit 0
                end
                ST_DATA: if (bit_tick) begin
                    if (bit_idx == 3'd7) begin
                        state   <= ST_STOP;
                        uart_tx <= 1'b1;              // Stop bit
                    end else begin
                        bit_idx <= bit_idx + 3'd1;
                        uart_tx <= shreg[1];          // Matches the shift below
                    end
                end
                ST_STOP: if (bit_tick) state <= ST_IDLE;  // Line stays high
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (pop) begin
            shreg <= pop_data;
        end else if (state == ST_DATA && bit_tick) begin
            shreg <= {1'b0, shreg[7:1]};             // LSB first
        end
    end

    a_idle_high: assert property (@(posedge Clock) disable iff (rst)
        (state == ST_IDLE) |-> uart_tx)
        else $error("UART line low while idle");

endmodule

`default_nettype wire

// File: verilog/baud_timer.sv
`timescale 1ns/1ps
`default_nettype none

module baud_timer import bridge_cfg_pkg::*; (
    input  logic Clock,    // System clock
    input  logic rst,      // Sync reset, active high
    input  logic run,      // High for the whole UART frame
    output logic bit_tick  // One cycle at the end of each bit period
);

    logic [BAUD_CW-1:0] cnt;  // Cycles left in the current bit

    // Tick on the last cycle of the period
    assign bit_tick = run && (cnt == '0);

    always_ff @(posedge Clock) begin
        if (rst || !run || cnt == '0) begin
            cnt <= BAUD_CW'(BIT_CYCLES - 1);  // Full period from here
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo import bridge_cfg_pkg::*, bridge_msg_pkg::*; (
    input  logic  Clock,      // System clock
    input  logic  rst,        // Sync reset, active high
    input  logic  push,       // Write strobe
    input  byte_t push_data,  // Byte to store
    input  logic  pop,        // Read strobe, only when not empty
    output byte_t pop_data,   // Head of queue, fall-through
    output logic  empty,
    output logic  full,
    output logic  overflow    // Sticky, a byte was dropped
);

    byte_t              mem [FIFO_DEPTH];  // Storage
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;             // Occupancy 0..FIFO_DEPTH
    logic               do_push;
    logic               do_pop;

    assign empty    = (count == '0);
    assign full     = (count == FIFO_DEPTH[FIFO_AW:0]);
    assign do_push  = push && !full;       // Push into a full queue is lost
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];         // Head always on the output

    always_ff @(posedge Clock) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // Pointers wrap at depth
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Idle or push with pop
            endcase
            if (push && full) overflow <= 1'b1;     // Held until reset
        end
    end

    a_no_pop_empty: assert property (@(posedge Clock) disable iff (rst)
        pop |-> !empty)
        else $error("pop while queue empty");

endmodule

`default_nettype wire

// File: verilog/spi_byte_rx.sv
`timescale 1ns/1ps
`default_nettype none

module spi_byte_rx import bridge_cfg_pkg::*, bridge_msg_pkg::*; (
    input  logic  Clock,     // System clock
    input  logic  rst,       // Sync reset, active high
    input  logic  sck,       // SPI clock from master, async
    input  logic  cs_n,      // Chip select, active low
    input  logic  mosi,      // Master out slave in
    output logic  miso,      // Master in slave out
    output byte_t rx_byte,   // Last completed byte, also the reply
    output logic  rx_valid,  // One cycle per completed byte
    output logic  cs_active  // Synced chip select level
);

    logic [SYNC_STAGES-1:0] sck_sync;   // Pin synchronizers
    logic [SYNC_STAGES-1:0] cs_sync;
    logic [SYNC_STAGES-1:0] mosi_sync;
    logic       sck_d;                  // Synced SCK one cycle back
    logic       cs_d;                   // cs_active one cycle back
    logic       sck_rise;
    logic       sck_fall;
    logic       cs_fall;
    logic [2:0] bit_cnt;                // Bits taken in the current byte
    logic [6:0] rx_shift;               // First seven bits of the byte in flight
    byte_t      tx_shift;               // Reply shifter, MSB on the pin

    assign cs_active = ~cs_sync[SYNC_STAGES-1];
    assign sck_rise  = sck_sync[SYNC_STAGES-1] & ~sck_d;  // Mode 0 sample edge
    assign sck_fall  = ~sck_sync[SYNC_STAGES-1] & sck_d;  // Mode 0 launch edge
    assign cs_fall   = cs_active & ~cs_d;                 // Frame start
    assign miso      = tx_shift[7];

    always_ff @(posedge Clock) begin
        if (rst) begin
            sck_sync  <= '0;
            cs_sync   <= '1;          // Deselected
            mosi_sync <= '0;
            sck_d     <= 1'b0;
            cs_d      <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[SYNC_STAGES-2:0], sck};
            cs_sync   <= {cs_sync[SYNC_STAGES-2:0], cs_n};
            mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], mosi};
            sck_d     <= sck_sync[SYNC_STAGES-1];
            cs_d      <= cs_active;
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
            rx_byte  <= '0;           // First reply after reset is zero
            tx_shift <= '0;
        end else begin
            rx_valid <= 1'b0;
            if (!cs_active) begin
                bit_cnt <= '0;        // Realign on every frame
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;  // Wraps after bit 7
                if (bit_cnt == 3'd7) begin
                    rx_byte  <= {rx_shift, mosi_sync[SYNC_STAGES-1]};
                    rx_valid <= 1'b1;
                end
            end
            if (cs_fall) begin
                tx_shift <= rx_byte;  // Reply ready before first rising SCK
            end else if (cs_active && sck_fall) begin
                // Byte boundary reloads the reply, else next bit
                tx_shift <= (bit_cnt == 3'd0) ? rx_byte : {tx_shift[6:0], 1'b0};
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (cs_active && sck_rise) begin
            rx_shift <= {rx_shift[5:0], mosi_sync[SYNC_STAGES-1]};  // MSB first
        end
    end

    a_valid_in_frame: assert property (@(posedge Clock) disable iff (rst)
        rx_valid |-> cs_active)
        else $error("rx_valid outside a chip select frame");

endmodule

`default_nettype wire

// File: verilog/bridge_msg_pkg.sv
`default_nettype none

package bridge_msg_pkg;

    // One byte on SPI, in the queue and on the UART
    typedef logic [7:0] byte_t;

    // Length of the debug message and width of an index into it
    localparam int MSG_LEN   = 16;
    localparam int MSG_IDX_W = $clog2(MSG_LEN);

    // "SPI debug data" followed by CR LF, entry 0 is sent first
    localparam byte_t DEBUG_MSG [MSG_LEN] = '{
        "S", "P", "I", " ",
        "d", "e", "b", "u",
        "g", " ", "d", "a",
        "t", "a", 8'h0D, 8'h0A
    };

endpackage

`default_nettype wire

// File: verilog/bridge_cfg_pkg.sv
`default_nettype none

package bridge_cfg_pkg;

    // Board clock and UART line rate
    localparam logic [31:0] CLOCK_HZ  = 32'd27_000_000;  // 27 MHz crystal
    localparam logic [31:0] BAUD_RATE = 32'd115_200;     // Debug console rate

    // Clock cycles per UART bit, rounds down to 234
    localparam int BIT_CYCLES = int'(CLOCK_HZ / BAUD_RATE);

    // Width of the bit period down counter
    localparam int BAUD_CW = $clog2(BIT_CYCLES);

    // Byte queue between SPI and UART
    localparam int FIFO_DEPTH = 64;  // Entries
    localparam int FIFO_AW    = 6;   // Address width, log2 of FIFO_DEPTH

    // Flops on each SPI pin before use in the Clock domain
    localparam int SYNC_STAGES = 2;

endpackage

`default_nettype wire
